// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= rv_idu.f
TOP       ?= tb_rv_idu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/decoded_inst_if.sv ====
// interface for the latched instruction fields shared by decoder, imm gen and register file
`default_nettype none
`include "rv_idu_defines.svh"

interface decoded_inst_if;
  import rv_idu_pkg::*;

  logic [`RV_INST_W-1:0]     inst;  // held instruction word
  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_REG_ADDR_W-1:0] rd;
  imm_sel_e                  imm_sel;

  modport producer (output inst, rs1, rs2, rd, imm_sel);
  modport consumer (input inst, rs1, rs2, rd, imm_sel);

endinterface

`default_nettype wire

// ==== rtl/gpr_file.sv ====
// 32 x 64 general-purpose register file, two async reads and one sync write port
`default_nettype none
`include "rv_idu_defines.svh"

module gpr_file (
  input  logic                      i_clk,
  input  logic                      i_reset,
  decoded_inst_if.consumer          dec,
  input  logic                      i_wen,
  input  logic [`RV_REG_ADDR_W-1:0] i_waddr,
  input  logic [`RV_XLEN-1:0]       i_wdata,
  output logic [`RV_XLEN-1:0]       o_rs1_data,
  output logic [`RV_XLEN-1:0]       o_rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin  // x0 is hardwired
      regs[i_waddr] <= i_wdata;
    end
  end

  // no same-cycle bypass
  assign o_rs1_data = regs[dec.rs1];
  assign o_rs2_data = regs[dec.rs2];

  // x0 holds zero from reset on, since the write port skips it
  assert property (@(posedge i_clk) disable iff (i_reset)
    (dec.rs1 == '0) |-> (o_rs1_data == '0));

  assert property (@(posedge i_clk) disable iff (i_reset)
    (dec.rs2 == '0) |-> (o_rs2_data == '0));

endmodule

`default_nettype wire

// ==== rtl/imm_gen.sv ====
// sign-extended immediate for the i, u, s, b and j formats
`default_nettype none
`include "rv_idu_defines.svh"

module imm_gen (
  decoded_inst_if.consumer     dec,
  output logic [`RV_XLEN-1:0]  o_imm
);
  import rv_idu_pkg::*;

  logic [`RV_INST_W-1:0] inst;
  logic                  sign;

  assign inst = dec.inst;
  assign sign = inst[31];

  always_comb begin
    case (dec.imm_sel)
      IMM_I: begin
        o_imm = {{52{sign}}, inst[31:20]};
      end
      IMM_U: begin
        o_imm = {{32{sign}}, inst[31:12], 12'b0};  // rv64 sign-extends bit 31
      end
      IMM_S: begin
        o_imm = {{52{sign}}, inst[31:25], inst[11:7]};
      end
      IMM_B: begin
        o_imm = {{52{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      IMM_J: begin
        o_imm = {{44{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: begin
        o_imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
// instruction latch and rv64i classification into alu, memory, branch and immediate controls
`default_nettype none
`include "rv_idu_defines.svh"

module inst_decoder (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_ifu_ready,
  input  logic [`RV_INST_W-1:0]  i_inst,
  decoded_inst_if.producer       dec,
  output logic                   o_alu_a_src,
  output rv_idu_pkg::alu_b_src_e o_alu_b_src,
  output rv_idu_pkg::alu_op_e    o_alu_op,
  output logic                   o_word_cut,
  output logic                   o_reg_wr,
  output logic                   o_mem_re,
  output logic                   o_mem_wr,
  output rv_idu_pkg::mem_op_e    o_mem_op,
  output logic                   o_bren,
  output rv_idu_pkg::br_func_e   o_brfunc,
  output logic                   o_invalid_inst
);
  import rv_idu_pkg::*;

  logic [`RV_INST_W-1:0] idu_inst;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      idu_inst <= '0;
    end else if (i_ifu_ready) begin
      idu_inst <= i_inst;
    end
  end

  assign dec.inst = idu_inst;
  assign dec.rs1  = idu_inst[19:15];
  assign dec.rs2  = idu_inst[24:20];
  assign dec.rd   = idu_inst[11:7];

  wire [6:0] opcode = idu_inst[6:0];
  wire [2:0] funct3 = idu_inst[14:12];
  wire [6:0] funct7 = idu_inst[31:25];
  wire       f7_base = (funct7 == `RV_F7_BASE);
  wire       f7_alt  = (funct7 == `RV_F7_ALT);
  wire       f6_base = ({funct7[6:1], 1'b0} == `RV_F7_BASE);  // bit 25 is shamt[5]

  wire op_branch = (opcode == `RV_OP_BRANCH);
  wire op_load   = (opcode == `RV_OP_LOAD);
  wire op_store  = (opcode == `RV_OP_STORE);
  wire op_imm    = (opcode == `RV_OP_IMM);
  wire op_imm32  = (opcode == `RV_OP_IMM32);
  wire op_reg    = (opcode == `RV_OP_REG);
  wire op_reg32  = (opcode == `RV_OP_REG32);

  wire inst_lui   = (opcode == `RV_OP_LUI);
  wire inst_auipc = (opcode == `RV_OP_AUIPC);
  wire inst_jal   = (opcode == `RV_OP_JAL);
  wire inst_jalr  = (opcode == `RV_OP_JALR) & (funct3 == 3'b000);

  wire inst_beq  = op_branch & (funct3 == 3'b000);
  wire inst_bne  = op_branch & (funct3 == 3'b001);
  wire inst_blt  = op_branch & (funct3 == 3'b100);
  wire inst_bge  = op_branch & (funct3 == 3'b101);
  wire inst_bltu = op_branch & (funct3 == 3'b110);
  wire inst_bgeu = op_branch & (funct3 == 3'b111);

  wire inst_load  = op_load & (funct3 != 3'b111);  // lb lh lw ld lbu lhu lwu
  wire inst_store = op_store & ~funct3[2];         // sb sh sw sd

  // shared alu selects, immediate form and register form
  wire sel_add  = (funct3 == `RV_F3_ADD_SUB);
  wire sel_sll  = (funct3 == `RV_F3_SLL);
  wire sel_slt  = (funct3 == `RV_F3_SLT);
  wire sel_sltu = (funct3 == `RV_F3_SLTU);
  wire sel_xor  = (funct3 == `RV_F3_XOR);
  wire sel_sr   = (funct3 == `RV_F3_SR);
  wire sel_or   = (funct3 == `RV_F3_OR);
  wire sel_and  = (funct3 == `RV_F3_AND);

  wire imm_shl = op_imm & sel_sll & f6_base;
  wire imm_srl = op_imm & sel_sr & f6_base;
  wire imm_sra = op_imm & sel_sr & (funct7[6:1] == `RV_F6_SRA);
  wire imm_alu = op_imm & (sel_add | sel_slt | sel_sltu | sel_xor | sel_or | sel_and);

  wire reg_alu = op_reg & f7_base;
  wire reg_sub = op_reg & f7_alt & sel_add;
  wire reg_sra = op_reg & f7_alt & sel_sr;

  wire w_addi = op_imm32 & sel_add;
  wire w_shi  = op_imm32 & ((sel_sll & f7_base) | (sel_sr & (f7_base | f7_alt)));
  wire w_reg  = op_reg32 & ((sel_add & (f7_base | f7_alt)) | (sel_sll & f7_base)
                | (sel_sr & (f7_base | f7_alt)));

  wire type_r = reg_alu | reg_sub | reg_sra | w_reg;
  wire type_i = inst_jalr | inst_load | imm_alu | imm_shl | imm_srl | imm_sra | w_addi | w_shi;
  wire type_u = inst_lui | inst_auipc;
  wire type_s = inst_store;
  wire type_b = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  wire type_j = inst_jal;
  wire any_op = type_r | type_i | type_u | type_s | type_b | type_j;

  // register and immediate forms share funct3, w forms share the base op
  wire alu_grp = type_r | imm_alu | imm_shl | imm_srl | imm_sra | w_addi | w_shi;

  assign o_alu_a_src    = inst_jal | inst_jalr | inst_auipc;  // pc as operand a
  assign o_word_cut     = w_addi | w_shi | w_reg;
  assign o_reg_wr       = type_r | type_i | type_u | type_j;
  assign o_mem_re       = inst_load;
  assign o_mem_wr       = inst_store;
  assign o_bren         = type_b | inst_jal | inst_jalr;
  assign o_invalid_inst = ~any_op & (idu_inst != '0);

  always_comb begin
    if (inst_jal || inst_jalr) o_alu_b_src = B_FOUR;
    else if (type_i || type_u || type_s) o_alu_b_src = B_IMM;
    else o_alu_b_src = B_RS2;
  end

  always_comb begin
    o_alu_op = ALU_INVALID;  // branches compare outside the alu
    if (inst_lui) o_alu_op = ALU_COPY_IMM;
    else if (inst_auipc || inst_jal || inst_jalr || inst_load || inst_store) o_alu_op = ALU_ADD;
    else if (alu_grp) begin
      case (funct3)
        `RV_F3_ADD_SUB: o_alu_op = ((op_reg | op_reg32) & f7_alt) ? ALU_SUB : ALU_ADD;
        `RV_F3_SLL:     o_alu_op = ALU_SLL;
        `RV_F3_SLT:     o_alu_op = ALU_SLT;
        `RV_F3_SLTU:    o_alu_op = ALU_SLTU;
        `RV_F3_XOR:     o_alu_op = ALU_XOR;
        `RV_F3_SR:      o_alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
        `RV_F3_OR:      o_alu_op = ALU_OR;
        default:        o_alu_op = ALU_AND;
      endcase
    end
  end

  always_comb begin
    o_mem_op = MEM_NONE;
    if (inst_load || inst_store) begin
      case (funct3)
        3'b000:  o_mem_op = MEM_SB;
        3'b001:  o_mem_op = MEM_SH;
        3'b010:  o_mem_op = MEM_SW;
        3'b011:  o_mem_op = MEM_SD;
        3'b100:  o_mem_op = MEM_UB;
        3'b101:  o_mem_op = MEM_UH;
        default: o_mem_op = MEM_UW;
      endcase
    end
  end

  always_comb begin
    if (inst_jalr) o_brfunc = BR_JALR;
    else if (type_b) o_brfunc = br_func_e'(funct3[2] ? funct3 : {2'b01, funct3[0]});  // beq..bgeu
    else o_brfunc = BR_JAL;
  end

  always_comb begin
    if (type_i) dec.imm_sel = IMM_I;
    else if (type_u) dec.imm_sel = IMM_U;
    else if (type_s) dec.imm_sel = IMM_S;
    else if (type_b) dec.imm_sel = IMM_B;
    else if (type_j) dec.imm_sel = IMM_J;
    else dec.imm_sel = IMM_NONE;
  end

  // load and store never decode together, whatever word is held
  assert property (@(posedge i_clk) disable iff (i_reset) !(o_mem_re && o_mem_wr));

  // bad encodings must not reach the register file or memory
  assert property (@(posedge i_clk) disable iff (i_reset)
    o_invalid_inst |-> (!o_reg_wr && !o_mem_wr));

endmodule

`default_nettype wire

// ==== rtl/rv_idu.sv ====
// decode stage top, decoder, immediate generator and register file on plain ports
`default_nettype none
`include "rv_idu_defines.svh"

module rv_idu (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_ifu_ready,
  input  logic [`RV_INST_W-1:0]     i_inst,
  input  logic                      i_wb_wen,
  input  logic [`RV_REG_ADDR_W-1:0] i_wb_waddr,
  input  logic [`RV_XLEN-1:0]       i_wb_wdata,
  output logic [`RV_REG_ADDR_W-1:0] o_rd,
  output logic [`RV_XLEN-1:0]       o_rs1_data,
  output logic [`RV_XLEN-1:0]       o_rs2_data,
  output logic [`RV_XLEN-1:0]       o_imm,
  output logic                      o_alu_a_src,
  output rv_idu_pkg::alu_b_src_e    o_alu_b_src,
  output rv_idu_pkg::alu_op_e       o_alu_op,
  output logic                      o_word_cut,
  output logic                      o_reg_wr,
  output logic                      o_mem_re,
  output logic                      o_mem_wr,
  output rv_idu_pkg::mem_op_e       o_mem_op,
  output logic                      o_bren,
  output rv_idu_pkg::br_func_e      o_brfunc,
  output logic                      o_invalid_inst
);

  decoded_inst_if dec_if ();

  assign o_rd = dec_if.rd;

  inst_decoder u_decoder (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_ifu_ready    (i_ifu_ready),
    .i_inst         (i_inst),
    .dec            (dec_if.producer),
    .o_alu_a_src    (o_alu_a_src),
    .o_alu_b_src    (o_alu_b_src),
    .o_alu_op       (o_alu_op),
    .o_word_cut     (o_word_cut),
    .o_reg_wr       (o_reg_wr),
    .o_mem_re       (o_mem_re),
    .o_mem_wr       (o_mem_wr),
    .o_mem_op       (o_mem_op),
    .o_bren         (o_bren),
    .o_brfunc       (o_brfunc),
    .o_invalid_inst (o_invalid_inst)
  );

  imm_gen u_imm_gen (
    .dec   (dec_if.consumer),
    .o_imm (o_imm)
  );

  gpr_file u_gprs (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .dec        (dec_if.consumer),
    .i_wen      (i_wb_wen),
    .i_waddr    (i_wb_waddr),
    .i_wdata    (i_wb_wdata),
    .o_rs1_data (o_rs1_data),
    .o_rs2_data (o_rs2_data)
  );

endmodule

`default_nettype wire

// ==== rtl/rv_idu_defines.svh ====
// datapath widths, register count, base opcodes and funct patterns
`ifndef RV_IDU_DEFINES_SVH
`define RV_IDU_DEFINES_SVH

`define RV_XLEN        64
`define RV_INST_W      32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32

// major opcodes, inst[6:0]
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_IMM      7'b0010011
`define RV_OP_IMM32    7'b0011011
`define RV_OP_REG      7'b0110011
`define RV_OP_REG32    7'b0111011

// funct7 / funct6 patterns
`define RV_F7_BASE     7'b0000000
`define RV_F7_ALT      7'b0100000
`define RV_F6_SRA      6'b010000  // rv64 srai, shamt is 6 bits

// funct3 of the integer alu group
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SR       3'b101  // srl and sra
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

`endif

// ==== rtl/rv_idu_pkg.sv ====
// decode-stage enums for alu op, memory op, branch function, immediate format, operand b
`default_nettype none

package rv_idu_pkg;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLT      = 5'd2,
    ALU_SLTU     = 5'd3,
    ALU_XOR      = 5'd4,
    ALU_AND      = 5'd5,
    ALU_OR       = 5'd6,
    ALU_SLL      = 5'd7,
    ALU_SRL      = 5'd8,
    ALU_SRA      = 5'd9,
    ALU_COPY_IMM = 5'd15,  // lui passes the immediate through
    ALU_INVALID  = 5'd31
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_SB   = 3'd0,  // signed byte, also used for sb
    MEM_UB   = 3'd1,
    MEM_SH   = 3'd2,
    MEM_UH   = 3'd3,
    MEM_SW   = 3'd4,
    MEM_UW   = 3'd5,
    MEM_SD   = 3'd6,
    MEM_NONE = 3'd7
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_JAL  = 3'd0,
    BR_JALR = 3'd1,
    BR_BEQ  = 3'd2,
    BR_BNE  = 3'd3,
    BR_BLT  = 3'd4,
    BR_BGE  = 3'd5,
    BR_BLTU = 3'd6,
    BR_BGEU = 3'd7
  } br_func_e;

  typedef enum logic [2:0] {
    IMM_I    = 3'd0,
    IMM_U    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_J    = 3'd4,
    IMM_NONE = 3'd7  // r-type, no immediate
  } imm_sel_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'd0,
    B_IMM  = 2'd1,
    B_FOUR = 2'd2  // return address pc + 4
  } alu_b_src_e;

endpackage

`default_nettype wire

// ==== rv_idu.f ====
+incdir+rtl
+incdir+tests
rtl/rv_idu_pkg.sv
rtl/decoded_inst_if.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/gpr_file.sv
rtl/rv_idu.sv
tests/tb_rv_idu.sv

// ==== tests/tb_rv_idu_vectors.svh ====
// decode table of instruction words with expected immediate, alu, memory, branch and flag values
`ifndef TB_RV_IDU_VECTORS_SVH
`define TB_RV_IDU_VECTORS_SVH

// columns: name, inst, imm, alu_op, a_src, b_src, mem_op, brfunc,
//          flags {word_cut, reg_wr, mem_re, mem_wr, bren, invalid}
task automatic load_table();
  add_row("addi", enc_i(5, 0, `RV_OP_IMM), 5, ALU_ADD, 0, B_IMM, MEM_NONE, 0, 6'b010000);
  add_row("addi_neg", enc_i(-3, 0, `RV_OP_IMM), -3, ALU_ADD, 0, B_IMM, MEM_NONE, 0, 6'b010000);
  add_row("sltiu", enc_i(2047, 3, `RV_OP_IMM), 2047, ALU_SLTU, 0, B_IMM, MEM_NONE, 0, 6'b010000);
  add_row("xori", enc_i(-2048, 4, `RV_OP_IMM), -2048, ALU_XOR, 0, B_IMM, MEM_NONE, 0, 6'b010000);
  add_row("slli", enc_i('h03f, 1, `RV_OP_IMM), 'h3f, ALU_SLL, 0, B_IMM, MEM_NONE, 0, 6'b010000);
  add_row("srai", enc_i('h421, 5, `RV_OP_IMM), 'h421, ALU_SRA, 0, B_IMM, MEM_NONE, 0, 6'b010000);
  add_row("add", enc_r(7'h00, 3, 2, 0, `RV_OP_REG), 0, ALU_ADD, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("sub", enc_r(7'h20, 3, 2, 0, `RV_OP_REG), 0, ALU_SUB, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("sll", enc_r(7'h00, 3, 2, 1, `RV_OP_REG), 0, ALU_SLL, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("slt", enc_r(7'h00, 3, 2, 2, `RV_OP_REG), 0, ALU_SLT, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("sltu", enc_r(7'h00, 3, 2, 3, `RV_OP_REG), 0, ALU_SLTU, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("xor", enc_r(7'h00, 3, 2, 4, `RV_OP_REG), 0, ALU_XOR, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("srl", enc_r(7'h00, 3, 2, 5, `RV_OP_REG), 0, ALU_SRL, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("sra", enc_r(7'h20, 3, 2, 5, `RV_OP_REG), 0, ALU_SRA, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("or", enc_r(7'h00, 3, 2, 6, `RV_OP_REG), 0, ALU_OR, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("and", enc_r(7'h00, 3, 2, 7, `RV_OP_REG), 0, ALU_AND, 0, B_RS2, MEM_NONE, 0, 6'b010000);
  add_row("addiw", enc_i(-1, 0, `RV_OP_IMM32), -1, ALU_ADD, 0, B_IMM, MEM_NONE, 0, 6'b110000);
  add_row("sraiw", enc_i('h405, 5, `RV_OP_IMM32), 'h405, ALU_SRA, 0, B_IMM, MEM_NONE, 0, 6'b110000);
  add_row("subw", enc_r(7'h20, 3, 2, 0, `RV_OP_REG32), 0, ALU_SUB, 0, B_RS2, MEM_NONE, 0, 6'b110000);
  add_row("sllw", enc_r(7'h00, 3, 2, 1, `RV_OP_REG32), 0, ALU_SLL, 0, B_RS2, MEM_NONE, 0, 6'b110000);
  add_row("srlw", enc_r(7'h00, 3, 2, 5, `RV_OP_REG32), 0, ALU_SRL, 0, B_RS2, MEM_NONE, 0, 6'b110000);
  add_row("lui_neg", enc_u('h80000, `RV_OP_LUI), 64'hffff_ffff_8000_0000, ALU_COPY_IMM, 0, B_IMM,
          MEM_NONE, 0, 6'b010000);
  add_row("lui_pos", enc_u('h12345, `RV_OP_LUI), 'h12345000, ALU_COPY_IMM, 0, B_IMM, MEM_NONE, 0,
          6'b010000);
  add_row("auipc", enc_u('hfffff, `RV_OP_AUIPC), -4096, ALU_ADD, 1, B_IMM, MEM_NONE, 0, 6'b010000);
  add_row("jal_pos", enc_j(2048), 2048, ALU_ADD, 1, B_FOUR, MEM_NONE, BR_JAL, 6'b010010);
  add_row("jal_neg", enc_j(-4), -4, ALU_ADD, 1, B_FOUR, MEM_NONE, BR_JAL, 6'b010010);
  add_row("jalr", enc_i(-8, 0, `RV_OP_JALR), -8, ALU_ADD, 1, B_FOUR, MEM_NONE, BR_JALR, 6'b010010);
  add_row("lb", enc_i(-1, 0, `RV_OP_LOAD), -1, ALU_ADD, 0, B_IMM, MEM_SB, 0, 6'b011000);
  add_row("lh", enc_i(12, 1, `RV_OP_LOAD), 12, ALU_ADD, 0, B_IMM, MEM_SH, 0, 6'b011000);
  add_row("lw", enc_i(16, 2, `RV_OP_LOAD), 16, ALU_ADD, 0, B_IMM, MEM_SW, 0, 6'b011000);
  add_row("ld", enc_i(-16, 3, `RV_OP_LOAD), -16, ALU_ADD, 0, B_IMM, MEM_SD, 0, 6'b011000);
  add_row("lbu", enc_i(1, 4, `RV_OP_LOAD), 1, ALU_ADD, 0, B_IMM, MEM_UB, 0, 6'b011000);
  add_row("lhu", enc_i(2, 5, `RV_OP_LOAD), 2, ALU_ADD, 0, B_IMM, MEM_UH, 0, 6'b011000);
  add_row("lwu", enc_i(4, 6, `RV_OP_LOAD), 4, ALU_ADD, 0, B_IMM, MEM_UW, 0, 6'b011000);
  add_row("sb", enc_s(-4, 0), -4, ALU_ADD, 0, B_IMM, MEM_SB, 0, 6'b000100);
  add_row("sh", enc_s(40, 1), 40, ALU_ADD, 0, B_IMM, MEM_SH, 0, 6'b000100);
  add_row("sw", enc_s(-2048, 2), -2048, ALU_ADD, 0, B_IMM, MEM_SW, 0, 6'b000100);
  add_row("sd", enc_s(2047, 3), 2047, ALU_ADD, 0, B_IMM, MEM_SD, 0, 6'b000100);
  add_row("beq", enc_b(16, 0), 16, ALU_INVALID, 0, B_RS2, MEM_NONE, BR_BEQ, 6'b000010);
  add_row("bne", enc_b(-16, 1), -16, ALU_INVALID, 0, B_RS2, MEM_NONE, BR_BNE, 6'b000010);
  add_row("blt", enc_b(4094, 4), 4094, ALU_INVALID, 0, B_RS2, MEM_NONE, BR_BLT, 6'b000010);
  add_row("bge", enc_b(-4096, 5), -4096, ALU_INVALID, 0, B_RS2, MEM_NONE, BR_BGE, 6'b000010);
  add_row("bltu", enc_b(8, 6), 8, ALU_INVALID, 0, B_RS2, MEM_NONE, BR_BLTU, 6'b000010);
  add_row("bgeu", enc_b(-2, 7), -2, ALU_INVALID, 0, B_RS2, MEM_NONE, BR_BGEU, 6'b000010);
  add_row("ecall", 32'h0000_0073, 0, ALU_INVALID, 0, B_RS2, MEM_NONE, 0, 6'b000001);
  add_row("mul", enc_r(7'h01, 3, 2, 0, `RV_OP_REG), 0, ALU_INVALID, 0, B_RS2, MEM_NONE, 0, 6'b000001);
  add_row("csrrw", 32'h3401_1073, 0, ALU_INVALID, 0, B_RS2, MEM_NONE, 0, 6'b000001);
  add_row("unused_op", 32'h0000_007f, 0, ALU_INVALID, 0, B_RS2, MEM_NONE, 0, 6'b000001);
  add_row("zero_word", 32'h0, 0, ALU_INVALID, 0, B_RS2, MEM_NONE, 0, 6'b000000);
endtask

`endif

// ==== tests/tb_rv_idu.sv ====
// testbench for the decode stage, register file checks and table-driven decode checks
`default_nettype none
`include "rv_idu_defines.svh"

module tb_rv_idu;
  import rv_idu_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int WB_CYCLES    = 40;
  localparam int MARGIN       = 20;

  logic        i_clk;
  logic        i_reset;
  logic        i_ifu_ready;
  logic [31:0] i_inst;
  logic        i_wb_wen;
  logic [4:0]  i_wb_waddr;
  logic [63:0] i_wb_wdata;

  logic [4:0]  o_rd;
  logic [63:0] o_rs1_data;
  logic [63:0] o_rs2_data;
  logic [63:0] o_imm;
  logic        o_alu_a_src;
  alu_b_src_e  o_alu_b_src;
  alu_op_e     o_alu_op;
  logic        o_word_cut;
  logic        o_reg_wr;
  logic        o_mem_re;
  logic        o_mem_wr;
  mem_op_e     o_mem_op;
  logic        o_bren;
  br_func_e    o_brfunc;
  logic        o_invalid_inst;

  // table columns
  string       names[$];
  logic [31:0] insts[$];
  logic [63:0] imms[$];
  logic [4:0]  alus[$];
  logic        a_srcs[$];
  logic [1:0]  b_srcs[$];
  logic [2:0]  mem_ops[$];
  logic [2:0]  brfuncs[$];
  logic [5:0]  flags[$];

  logic [63:0] reg_model [32];
  int          cycles;
  int          limit;

  rv_idu UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // risc-v instruction formats, rd = x1, rs1 = x2, rs2 = x3 unless given
  function automatic logic [31:0] enc_i(input int imm, input logic [2:0] f3,
                                        input logic [6:0] op);
    return {imm[11:0], 5'd2, f3, 5'd1, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [6:0] op);
    return {f7, rs2, rs1, f3, 5'd1, op};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input logic [2:0] f3);
    return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd3, 5'd2, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input int imm, input logic [6:0] op);
    return {imm[19:0], 5'd1, op};
  endfunction

  function automatic logic [31:0] enc_j(input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `RV_OP_JAL};
  endfunction

  task automatic add_row(input string name, input logic [31:0] inst, input longint imm,
                         input logic [4:0] alu, input logic a_src, input logic [1:0] b_src,
                         input logic [2:0] mem_op, input logic [2:0] brfunc,
                         input logic [5:0] flag_bits);
    names.push_back(name);
    insts.push_back(inst);
    imms.push_back(imm);
    alus.push_back(alu);
    a_srcs.push_back(a_src);
    b_srcs.push_back(b_src);
    mem_ops.push_back(mem_op);
    brfuncs.push_back(brfunc);
    flags.push_back(flag_bits);
  endtask

  `include "tb_rv_idu_vectors.svh"

  task automatic check_row(input int r);
    string n;
    n = names[r];
    check({n, ".imm"}, imms[r], o_imm);
    check({n, ".alu_op"}, 64'(alus[r]), 64'(o_alu_op));
    check({n, ".alu_a_src"}, 64'(a_srcs[r]), 64'(o_alu_a_src));
    check({n, ".alu_b_src"}, 64'(b_srcs[r]), 64'(o_alu_b_src));
    check({n, ".mem_op"}, 64'(mem_ops[r]), 64'(o_mem_op));
    check({n, ".flags"}, 64'(flags[r]),
          64'({o_word_cut, o_reg_wr, o_mem_re, o_mem_wr, o_bren, o_invalid_inst}));
    if (flags[r][1]) begin  // branch function only means something with bren
      check({n, ".brfunc"}, 64'(brfuncs[r]), 64'(o_brfunc));
    end
  endtask

  initial begin
    void'($urandom(71));
    cycles = 0;
    i_reset = 1'b1;
    i_ifu_ready = 1'b0;
    i_inst = '0;
    i_wb_wen = 1'b0;
    i_wb_waddr = '0;
    i_wb_wdata = '0;
    load_table();
    limit = RESET_CYCLES + names.size() + WB_CYCLES + MARGIN;

    repeat (RESET_CYCLES) @(negedge i_clk);
    i_reset = 1'b0;
    @(negedge i_clk);

    // zero instruction after reset
    check("reset.flags", 64'd0,
          64'({o_word_cut, o_reg_wr, o_mem_re, o_mem_wr, o_bren, o_invalid_inst}));
    check("reset.mem_op", 64'(MEM_NONE), 64'(o_mem_op));
    check("reset.alu_op", 64'(ALU_INVALID), 64'(o_alu_op));
    check("reset.rs1_data", 64'd0, o_rs1_data);
    check("reset.rs2_data", 64'd0, o_rs2_data);

    // fill x1..x31, then try to write x0
    reg_model[0] = '0;
    i_wb_wen = 1'b1;
    for (int i = 1; i < 32; i++) begin
      reg_model[i] = {$urandom, $urandom};
      i_wb_waddr = 5'(i);
      i_wb_wdata = reg_model[i];
      @(negedge i_clk);
    end
    i_wb_waddr = '0;
    i_wb_wdata = 64'hdead_beef_cafe_f00d;
    @(negedge i_clk);
    i_wb_wen = 1'b0;

    i_ifu_ready = 1'b1;
    for (int k = 0; k < 17; k++) begin
      logic [4:0] ra;
      logic [4:0] rb;
      ra = (k == 16) ? 5'd0 : 5'(k + 1);
      rb = (k == 16) ? 5'd0 : 5'(k + 16);
      i_inst = enc_r(7'h00, rb, ra, 0, `RV_OP_REG);
      @(negedge i_clk);
      check($sformatf("gpr.rs1_x%0d", ra), reg_model[ra], o_rs1_data);
      check($sformatf("gpr.rs2_x%0d", rb), reg_model[rb], o_rs2_data);
      check("gpr.rd", 64'd1, 64'(o_rd));
    end

    for (int r = 0; r < names.size(); r++) begin
      i_inst = insts[r];
      @(negedge i_clk);
      check_row(r);
    end

    // held decode with the strobe low
    i_ifu_ready = 1'b0;
    i_inst = enc_i(5, 0, `RV_OP_IMM);
    @(negedge i_clk);
    check_row(names.size() - 1);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
